/* alien_fleet.sv */
module alien_fleet #(
  parameter int MARCH_DIV = 50000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_restart,
  input  space_pkg::coord_t i_bullet_x,
  input  space_pkg::coord_t i_bullet_y,
  input  logic              i_bullet_active,
  output logic              o_hit,
  output logic              o_won,
  output logic [space_pkg::NUM_ROWS*space_pkg::NUM_COLS-1:0] o_alive,
  output space_pkg::coord_t o_march_x,
  output space_pkg::score_t o_score
);
  import space_pkg::*;

  localparam int NUM_ALIENS = NUM_ROWS * NUM_COLS;
  localparam int MARCH_CW   = $clog2(MARCH_DIV + 1);

  logic [MARCH_CW-1:0] march_cnt;
  logic                march_right;  // Current march direction
  logic [5:0]          remaining;    // Live aliens
  logic                hit_found;
  logic [5:0]          hit_idx;
  logic [2:0]          hit_row;
  coord_t              ax, ay;       // Box origin under test
  logic                start;

  assign start = i_restart | o_won;

  // Row-major scan, first live alien overlapping the bullet
  always_comb begin
    hit_found = 1'b0;
    hit_idx   = '0;
    hit_row   = '0;
    ax        = '0;
    ay        = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        ax = GRID_X0 + coord_t'(c) * ALIEN_PITCH_X + o_march_x;
        ay = GRID_Y0 + coord_t'(r) * ALIEN_PITCH_Y;
        if (!hit_found && o_alive[r*NUM_COLS+c] &&
            i_bullet_x + BULLET_W >= ax && i_bullet_x <= ax + ALIEN_SIZE &&
            i_bullet_y <= ay + ALIEN_SIZE && i_bullet_y + BULLET_H >= ay) begin
          hit_found = 1'b1;
          hit_idx   = 6'(r * NUM_COLS + c);
          hit_row   = 3'(r);
        end
      end
    end
    // Bullet already spent while the strobe is high
    hit_found = hit_found & i_bullet_active & ~o_hit;
  end

  // Health grid, score and strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_alive   <= '1;
      remaining <= 6'(NUM_ALIENS);
      o_score   <= '0;
      o_hit     <= 1'b0;
      o_won     <= 1'b0;
    end else if (start) begin
      o_alive   <= '1;  // Revive the fleet
      remaining <= 6'(NUM_ALIENS);
      o_score   <= '0;
      o_hit     <= 1'b0;
      o_won     <= 1'b0;
    end else begin
      o_hit <= hit_found;
      o_won <= (remaining == '0);  // One cycle after the last kill
      if (hit_found) begin
        o_alive[hit_idx] <= 1'b0;
        remaining        <= remaining - 6'd1;
        o_score          <= o_score + ROW_POINTS[hit_row];
      end
    end
  end

  // Horizontal march, bounces between 0 and MARCH_MAX
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_march_x   <= '0;
      march_right <= 1'b1;
      march_cnt   <= '0;
    end else if (start) begin
      o_march_x   <= '0;
      march_right <= 1'b1;
      march_cnt   <= '0;
    end else if (march_cnt == MARCH_CW'(MARCH_DIV - 1)) begin
      march_cnt <= '0;
      if (march_right) begin
        if (o_march_x < MARCH_MAX) o_march_x <= o_march_x + 10'd1;
        else march_right <= 1'b0;  // Turn at the right edge
      end else begin
        if (o_march_x > '0) o_march_x <= o_march_x - 10'd1;
        else march_right <= 1'b1;
      end
    end else begin
      march_cnt <= march_cnt + 1'b1;
    end
  end

endmodule

/* flist.f */
space_pkg.sv
vga_timing.sv
player_control.sv
alien_fleet.sv
frame_renderer.sv
invaders_top.sv
invaders_sva.sv
tb_invaders.sv

/* frame_renderer.sv */
module frame_renderer (
  input  logic              clk,
  input  logic              rst_n,
  input  space_pkg::coord_t i_hpos,
  input  space_pkg::coord_t i_vpos,
  input  logic              i_active,
  input  logic              i_hsync,
  input  logic              i_vsync,
  input  logic [space_pkg::NUM_ROWS*space_pkg::NUM_COLS-1:0] i_alive,
  input  space_pkg::coord_t i_march_x,
  input  space_pkg::coord_t i_shooter_x,
  input  space_pkg::coord_t i_bullet_x,
  input  space_pkg::coord_t i_bullet_y,
  input  logic              i_bullet_active,
  input  space_pkg::score_t i_score,
  output logic              o_red,
  output logic              o_green,
  output logic              o_blue,
  output logic              o_hsync,
  output logic              o_vsync
);
  import space_pkg::*;

  localparam coord_t DIGIT_W = 10'd10;
  localparam coord_t DIGIT_H = 10'd14;

  logic [2:0] alien_rgb;   // Zero when no alien pixel
  logic       shooter_pix, bullet_pix, score_pix;
  logic [3:0] digit [3];   // Hundreds, tens, ones
  coord_t     ax, ay, dx, dy;
  coord_t     sdx, sdy;    // Offset inside a digit box
  logic       red, green, blue;

  // Sprite lookup at half resolution
  function automatic logic sprite_bit(input int cls, input logic [3:0] sx, input logic [3:0] sy);
    case (cls)
      0:       return (sx < 4'd8 && sy < 4'd8) ? SPRITE_SMALL[sy[2:0]][sx[2:0]] : 1'b0;
      1:       return (sx < 4'd12 && sy < 4'd12) ? SPRITE_MEDIUM[sy][sx] : 1'b0;
      default: return (sx < 4'd10 && sy < 4'd10) ? SPRITE_LARGE[sy][sx] : 1'b0;
    endcase
  endfunction

  // Seven-segment cell, 10x14 box
  function automatic logic seg_bit(input logic [6:0] s, input coord_t x, input coord_t y);
    logic mid_x;
    mid_x = (x >= 10'd2 && x < 10'd8);
    return (s[0] && y < 10'd2 && mid_x) ||
           (s[1] && x >= 10'd8 && y >= 10'd2 && y < 10'd7) ||
           (s[2] && x >= 10'd8 && y >= 10'd7 && y < 10'd12) ||
           (s[3] && y >= 10'd12 && mid_x) ||
           (s[4] && x < 10'd2 && y >= 10'd7 && y < 10'd12) ||
           (s[5] && x < 10'd2 && y >= 10'd2 && y < 10'd7) ||
           (s[6] && y >= 10'd7 && y < 10'd9 && mid_x);
  endfunction

  always_comb begin
    alien_rgb = '0;
    ax        = '0;
    ay        = '0;
    dx        = '0;
    dy        = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        ax = GRID_X0 + coord_t'(c) * ALIEN_PITCH_X + i_march_x;
        ay = GRID_Y0 + coord_t'(r) * ALIEN_PITCH_Y;
        dx = i_hpos - ax;
        dy = i_vpos - ay;
        if (i_alive[r*NUM_COLS+c] && i_hpos >= ax && dx < ALIEN_SIZE &&
            i_vpos >= ay && dy < ALIEN_SIZE &&
            sprite_bit((r == 0) ? 0 : (r < 3) ? 1 : 2, dx[4:1], dy[4:1])) begin
          alien_rgb = ROW_COLOR[(r == 0) ? 0 : (r < 3) ? 1 : 2];
        end
      end
    end
  end

  // Three stacked bars
  assign shooter_pix =
    (i_vpos >= SHOOTER_Y && i_vpos < SHOOTER_Y + 10'd2 &&
     i_hpos >= i_shooter_x + 10'd6 && i_hpos < i_shooter_x + 10'd14) ||
    (i_vpos >= SHOOTER_Y + 10'd2 && i_vpos < SHOOTER_Y + 10'd8 &&
     i_hpos >= i_shooter_x + 10'd8 && i_hpos < i_shooter_x + 10'd12) ||
    (i_vpos >= SHOOTER_Y + 10'd8 && i_vpos < SHOOTER_Y + 10'd10 &&
     i_hpos >= i_shooter_x + 10'd4 && i_hpos < i_shooter_x + 10'd16);

  assign bullet_pix = i_bullet_active &&
                      i_hpos >= i_bullet_x && i_hpos < i_bullet_x + BULLET_W &&
                      i_vpos >= i_bullet_y && i_vpos < i_bullet_y + BULLET_H;

  always_comb begin
    digit[0]  = 4'(i_score / 10'd100);
    digit[1]  = 4'((i_score / 10'd10) % 10'd10);
    digit[2]  = 4'(i_score % 10'd10);
    score_pix = 1'b0;
    sdx       = '0;
    sdy       = i_vpos - DIGIT_Y;
    for (int d = 0; d < 3; d++) begin
      sdx = i_hpos - DIGIT_X[d];
      if (i_hpos >= DIGIT_X[d] && sdx < DIGIT_W && i_vpos >= DIGIT_Y && sdy < DIGIT_H &&
          seg_bit(SEG_FONT[digit[d]], sdx, sdy)) begin
        score_pix = 1'b1;
      end
    end
  end

  // Colour merge
  assign red   = alien_rgb[2] | bullet_pix | score_pix;
  assign green = alien_rgb[1] | bullet_pix | shooter_pix;
  assign blue  = alien_rgb[0] | bullet_pix | shooter_pix;

  // One stage, syncs delayed with the colour
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_red   <= 1'b0;
      o_green <= 1'b0;
      o_blue  <= 1'b0;
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
    end else begin
      o_red   <= i_active & red;    // Black in blanking
      o_green <= i_active & green;
      o_blue  <= i_active & blue;
      o_hsync <= i_hsync;
      o_vsync <= i_vsync;
    end
  end

endmodule

/* invaders_sva.sv */
module invaders_sva (
  input logic              clk,
  input logic              rst_n,
  input logic              i_hit,
  input logic              i_won,
  input space_pkg::score_t i_score,
  input logic              i_hsync,
  input logic              i_vsync
);

  logic [6:0]  hlow_cnt;  // Cycles of hsync low so far
  logic [10:0] vlow_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hlow_cnt <= '0;
      vlow_cnt <= '0;
    end else begin
      hlow_cnt <= i_hsync ? '0 : hlow_cnt + 7'd1;
      vlow_cnt <= i_vsync ? '0 : vlow_cnt + 11'd1;
    end
  end

  // Strobes last exactly one cycle
  hit_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) i_hit |=> !i_hit)
    else $error("hit strobe high for two cycles");
  won_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) i_won |=> !i_won)
    else $error("won strobe high for two cycles");

  won_clears_score: assert property (@(posedge clk) disable iff (!rst_n)
    i_won |=> (i_score == '0))
    else $error("score not cleared after the won strobe");

  // Width checked as the pulse ends
  hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(i_hsync) |-> (hlow_cnt == 7'd96))
    else $error("hsync low width is not 96 cycles");
  vsync_width: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(i_vsync) |-> (vlow_cnt == 11'd1600))
    else $error("vsync low width is not 1600 cycles");

endmodule

bind invaders_top invaders_sva u_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .i_hit   (hit),
  .i_won   (o_won),
  .i_score (o_score),
  .i_hsync (o_hsync),
  .i_vsync (o_vsync)
);

/* invaders_top.sv */
module invaders_top #(
  parameter int MOVE_DIV   = 500000,
  parameter int BULLET_DIV = 3000,
  parameter int MARCH_DIV  = 50000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_right,
  input  logic              i_left,
  input  logic              i_fire,
  input  logic              i_restart,
  output logic              o_hsync,
  output logic              o_vsync,
  output logic              o_red,
  output logic              o_green,
  output logic              o_blue,
  output space_pkg::score_t o_score,
  output logic              o_won
);
  import space_pkg::*;

  coord_t hpos, vpos;
  logic   active, hsync_raw, vsync_raw;  // Undelayed syncs
  coord_t shooter_x, bullet_x, bullet_y, march_x;
  logic   bullet_active, hit;
  logic [NUM_ROWS*NUM_COLS-1:0] alive;

  vga_timing u_timing (
    .clk      (clk),
    .rst_n    (rst_n),
    .o_hpos   (hpos),
    .o_vpos   (vpos),
    .o_active (active),
    .o_hsync  (hsync_raw),
    .o_vsync  (vsync_raw)
  );

  player_control #(
    .MOVE_DIV   (MOVE_DIV),
    .BULLET_DIV (BULLET_DIV)
  ) u_player (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_right         (i_right),
    .i_left          (i_left),
    .i_fire          (i_fire),
    .i_restart       (i_restart),
    .i_hit           (hit),
    .i_won           (o_won),
    .o_shooter_x     (shooter_x),
    .o_bullet_x      (bullet_x),
    .o_bullet_y      (bullet_y),
    .o_bullet_active (bullet_active)
  );

  alien_fleet #(
    .MARCH_DIV (MARCH_DIV)
  ) u_fleet (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_restart       (i_restart),
    .i_bullet_x      (bullet_x),
    .i_bullet_y      (bullet_y),
    .i_bullet_active (bullet_active),
    .o_hit           (hit),
    .o_won           (o_won),
    .o_alive         (alive),
    .o_march_x       (march_x),
    .o_score         (o_score)
  );

  frame_renderer u_render (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_hpos          (hpos),
    .i_vpos          (vpos),
    .i_active        (active),
    .i_hsync         (hsync_raw),
    .i_vsync         (vsync_raw),
    .i_alive         (alive),
    .i_march_x       (march_x),
    .i_shooter_x     (shooter_x),
    .i_bullet_x      (bullet_x),
    .i_bullet_y      (bullet_y),
    .i_bullet_active (bullet_active),
    .i_score         (o_score),
    .o_red           (o_red),
    .o_green         (o_green),
    .o_blue          (o_blue),
    .o_hsync         (o_hsync),
    .o_vsync         (o_vsync)
  );

endmodule

/* player_control.sv */
module player_control #(
  parameter int MOVE_DIV   = 500000,
  parameter int BULLET_DIV = 3000
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_right,
  input  logic              i_left,
  input  logic              i_fire,
  input  logic              i_restart,
  input  logic              i_hit,
  input  logic              i_won,
  output space_pkg::coord_t o_shooter_x,
  output space_pkg::coord_t o_bullet_x,
  output space_pkg::coord_t o_bullet_y,
  output logic              o_bullet_active
);
  import space_pkg::*;

  localparam int MOVE_CW   = $clog2(MOVE_DIV + 1);
  localparam int BULLET_CW = $clog2(BULLET_DIV + 1);

  localparam logic [1:0] DIR_IDLE  = 2'd0;
  localparam logic [1:0] DIR_LEFT  = 2'd1;
  localparam logic [1:0] DIR_RIGHT = 2'd2;

  logic                 right_q, left_q, fire_q;  // Button history
  logic                 right_rise, left_rise, fire_rise;
  logic [1:0]           dir;
  logic [MOVE_CW-1:0]   move_cnt;
  logic [BULLET_CW-1:0] bullet_cnt;
  logic                 move_tick, bullet_tick;
  logic                 start;

  assign right_rise  = i_right & ~right_q;
  assign left_rise   = i_left & ~left_q;
  assign fire_rise   = i_fire & ~fire_q;
  assign start       = i_restart | i_won;  // Back to the start state
  assign move_tick   = (move_cnt == MOVE_CW'(MOVE_DIV - 1));
  assign bullet_tick = (bullet_cnt == BULLET_CW'(BULLET_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      right_q <= 1'b0;
      left_q  <= 1'b0;
      fire_q  <= 1'b0;
      dir     <= DIR_IDLE;
    end else begin
      right_q <= i_right;
      left_q  <= i_left;
      fire_q  <= i_fire;
      // Last pressed button wins
      if (right_rise) begin
        dir <= DIR_RIGHT;
      end else if (left_rise) begin
        dir <= DIR_LEFT;
      end else if (!i_right && !i_left) begin
        dir <= DIR_IDLE;
      end
    end
  end

  // Shooter steps on divider ticks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_shooter_x <= SHOOTER_START_X;
      move_cnt    <= '0;
    end else if (start) begin
      o_shooter_x <= SHOOTER_START_X;
      move_cnt    <= '0;
    end else begin
      move_cnt <= move_tick ? '0 : move_cnt + 1'b1;
      if (move_tick && dir == DIR_RIGHT) begin
        o_shooter_x <= (o_shooter_x + SHOOTER_STEP <= SHOOTER_MAX_X) ?
                       o_shooter_x + SHOOTER_STEP : SHOOTER_MAX_X;  // Clamp right
      end else if (move_tick && dir == DIR_LEFT) begin
        o_shooter_x <= (o_shooter_x >= SHOOTER_MIN_X + SHOOTER_STEP) ?
                       o_shooter_x - SHOOTER_STEP : SHOOTER_MIN_X;  // Clamp left
      end
    end
  end

  // Single bullet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_bullet_active <= 1'b0;
      o_bullet_x      <= '0;
      o_bullet_y      <= '0;
      bullet_cnt      <= '0;
    end else if (start || i_hit) begin
      o_bullet_active <= 1'b0;  // Consumed by a hit, no fire this cycle
      bullet_cnt      <= '0;
    end else if (o_bullet_active) begin
      bullet_cnt <= bullet_tick ? '0 : bullet_cnt + 1'b1;
      if (bullet_tick) begin
        if (o_bullet_y == '0) begin
          o_bullet_active <= 1'b0;  // Off the top
        end else begin
          o_bullet_y <= o_bullet_y - 10'd1;
        end
      end
    end else if (fire_rise) begin
      o_bullet_active <= 1'b1;
      o_bullet_x      <= o_shooter_x + 10'd4;  // Gun barrel
      o_bullet_y      <= BULLET_START_Y;
      bullet_cnt      <= '0;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_invaders \
  -f flist.f -o sim_invaders
./obj_dir/sim_invaders | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

/* space_pkg.sv */
package space_pkg;

  typedef logic [9:0] coord_t;  // Pixel coordinate
  typedef logic [9:0] score_t;  // Up to 990 points

  // 640x480 at 800x525 total
  localparam coord_t H_ACTIVE     = 10'd640;
  localparam coord_t H_TOTAL      = 10'd800;
  localparam coord_t H_SYNC_START = 10'd656;
  localparam coord_t H_SYNC_END   = 10'd752;
  localparam coord_t V_ACTIVE     = 10'd480;
  localparam coord_t V_TOTAL      = 10'd525;
  localparam coord_t V_SYNC_START = 10'd490;
  localparam coord_t V_SYNC_END   = 10'd492;

  // Alien grid
  localparam int     NUM_ROWS      = 5;
  localparam int     NUM_COLS      = 11;
  localparam coord_t ALIEN_SIZE    = 10'd24;   // Box of a doubled sprite
  localparam coord_t ALIEN_PITCH_X = 10'd30;
  localparam coord_t ALIEN_PITCH_Y = 10'd32;
  localparam coord_t GRID_X0       = 10'd70;
  localparam coord_t GRID_Y0       = 10'd150;
  localparam coord_t MARCH_MAX     = 10'd100;

  // Shooter and bullet
  localparam coord_t SHOOTER_Y       = 10'd460;
  localparam coord_t SHOOTER_START_X = 10'd253;
  localparam coord_t SHOOTER_MIN_X   = 10'd10;
  localparam coord_t SHOOTER_MAX_X   = 10'd528;
  localparam coord_t SHOOTER_STEP    = 10'd10;
  localparam coord_t BULLET_W        = 10'd4;
  localparam coord_t BULLET_H        = 10'd8;
  localparam coord_t BULLET_START_Y  = 10'd460;

  // Score digits, hundreds first
  localparam coord_t DIGIT_Y    = 10'd20;
  localparam coord_t DIGIT_X [3] = '{10'd30, 10'd60, 10'd90};

  // Top row, bit 0 is the leftmost column
  localparam logic [7:0] SPRITE_SMALL [8] = '{
    8'b00011000,
    8'b00111100,
    8'b01111110,
    8'b11011011,
    8'b11111111,
    8'b00100100,
    8'b01000010,
    8'b10000001
  };

  // Rows 1 and 2
  localparam logic [11:0] SPRITE_MEDIUM [12] = '{
    12'b000011100000,
    12'b000111110000,
    12'b001111111000,
    12'b011011101100,
    12'b111111111110,
    12'b101111111010,
    12'b101001100010,
    12'b101000000010,
    12'b001100110000,
    12'b010000001000,
    12'b100000000100,
    12'b000000000000
  };

  // Rows 3 and 4
  localparam logic [9:0] SPRITE_LARGE [10] = '{
    10'b0011111100,
    10'b0111111110,
    10'b1101101101,
    10'b1111111111,
    10'b0111111110,
    10'b0010010010,
    10'b0100000100,
    10'b1000000010,
    10'b1100000110,
    10'b0111111110
  };

  // Segments gfedcba
  localparam logic [6:0] SEG_FONT [10] = '{
    7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
    7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111
  };

  localparam logic [2:0] ROW_COLOR [3] = '{3'b011, 3'b101, 3'b110};  // Per sprite class, RGB
  localparam score_t ROW_POINTS [5] = '{10'd30, 10'd20, 10'd20, 10'd10, 10'd10};

endpackage

/* tb_invaders.sv */
module tb_invaders;

  localparam int ACT_FIRE    = 0;
  localparam int ACT_RIGHT   = 1;
  localparam int ACT_LEFT    = 2;
  localparam int ACT_RESTART = 3;
  localparam int NO_CHECK    = -1;  // Step has no score check

  localparam int ROW_VALUE [5] = '{30, 20, 20, 10, 10};  // Points, top row first

  logic       clk = 1'b0;
  logic       rst_n;
  logic       i_right, i_left, i_fire, i_restart;
  logic       o_hsync, o_vsync;
  logic       o_red, o_green, o_blue;
  logic [9:0] o_score;
  logic       o_won;

  // Stimulus table, one entry per step
  int    step_test [$];
  int    step_act  [$];
  int    step_hold [$];  // Cycles the button is held
  int    step_exp  [$];  // Score after the step
  string test_name [6];

  int checks    = 0;
  int errors    = 0;
  int won_count = 0;

  invaders_top #(
    .MOVE_DIV   (4),
    .BULLET_DIV (1),
    .MARCH_DIV  (100000000)  // Fleet stays put
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_right   (i_right),
    .i_left    (i_left),
    .i_fire    (i_fire),
    .i_restart (i_restart),
    .o_hsync   (o_hsync),
    .o_vsync   (o_vsync),
    .o_red     (o_red),
    .o_green   (o_green),
    .o_blue    (o_blue),
    .o_score   (o_score),
    .o_won     (o_won)
  );

  always #5 clk = ~clk;

  // Count game-won strobes over the whole run
  always @(negedge clk) begin
    if (rst_n && o_won) won_count <= won_count + 1;
  end

  task automatic compare_value(input string what, input int got, input int want);
    checks++;
    if (got != want) begin
      $display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    checks++;
    errors++;
    $display("timeout at time %0t: %s", $time, what);
  endtask

  task automatic report_test(input int num, input int err_before);
    $display("test %0d (%s) finished with %0d errors", num, test_name[num],
             errors - err_before);
  endtask

  // Falling edge of a sync output, cycles counted from the call
  task automatic wait_sync_fall(input bit vert, input int limit, output bit ok,
                                output int cycles);
    logic prev, cur;
    ok     = 1'b0;
    cycles = 0;
    @(negedge clk);
    prev = vert ? o_vsync : o_hsync;
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      cur = vert ? o_vsync : o_hsync;
      if (prev && !cur) begin
        ok     = 1'b1;
        cycles = i + 2;
        break;
      end
      prev = cur;
    end
  endtask

  // Low width, starting on the falling-edge cycle
  task automatic measure_low(input bit vert, input int limit, output int width);
    width = 1;
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      if (vert ? o_vsync : o_hsync) break;
      width++;
    end
    if (width > limit) note_timeout("sync output stuck low");
  endtask

  task automatic wait_strobe(input bit won_sel, input int limit, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      if (won_sel ? o_won : UUT.hit) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic check_sync_timing();
    bit ok;
    int cycles;
    int width;
    wait_sync_fall(1'b0, 1000, ok, cycles);
    if (!ok) note_timeout("hsync never fell");
    wait_sync_fall(1'b0, 1000, ok, cycles);
    if (!ok) note_timeout("second hsync fall missing");
    else compare_value("hsync period", cycles, 800);
    measure_low(1'b0, 1000, width);
    compare_value("hsync low width", width, 96);
    wait_sync_fall(1'b1, 430000, ok, cycles);  // Up to a full frame
    if (!ok) begin
      note_timeout("vsync never fell");
    end else begin
      measure_low(1'b1, 2000, width);
      compare_value("vsync low width", width, 1600);  // Two lines
    end
  endtask

  // One full frame, each line indexed from its hsync fall
  task automatic check_blanking();
    bit         ok;
    int         cycles;
    int         bad;
    int         lit;
    logic [2:0] rgb;
    lit = 0;
    wait_sync_fall(1'b0, 1000, ok, cycles);
    if (!ok) note_timeout("hsync never fell before the blanking check");
    for (int line = 0; line < 525; line++) begin
      bad = 0;
      for (int i = 0; i < 800; i++) begin
        rgb = {o_red, o_green, o_blue};
        if (i < 144 || i >= 784) begin
          if (rgb != 3'b000) bad++;  // Back porch, sync or front porch
        end else if (rgb != 3'b000) begin
          lit++;
        end
        @(negedge clk);
      end
      checks++;
      if (bad != 0) begin
        $display("mismatch at time %0t: %0d lit pixels in the blanking of line %0d",
                 $time, bad, line);
        errors++;
      end
    end
    checks++;
    if (lit == 0) begin
      $display("no pixel was lit in the visible area of a whole frame");
      errors++;
    end
  endtask

  task automatic add_step(input int test, input int act, input int hold, input int expected);
    step_test.push_back(test);
    step_act.push_back(act);
    step_hold.push_back(hold);
    step_exp.push_back(expected);
  endtask

  task automatic build_table();
    int total;
    total        = 0;
    test_name[1] = "sync timing";
    test_name[2] = "blanking";
    test_name[3] = "column fire";
    test_name[4] = "restart";
    test_name[5] = "full sweep";
    // Shooter at x=253, bullet hits column 6 bottom up
    add_step(3, ACT_FIRE, 2, 10);
    add_step(3, ACT_FIRE, 2, 20);
    add_step(3, ACT_FIRE, 2, 40);
    add_step(3, ACT_FIRE, 2, 60);
    add_step(3, ACT_FIRE, 2, 90);
    add_step(4, ACT_RESTART, 3, 0);
    add_step(4, ACT_FIRE, 2, 10);   // Fleet revived
    add_step(5, ACT_RESTART, 3, 0);
    add_step(5, ACT_LEFT, 120, NO_CHECK);  // Park on the left limit, x=10
    for (int c = 0; c < 11; c++) begin
      // 4 cycles per step; 6 steps to x=70, then one alien pitch
      add_step(5, ACT_RIGHT, (c == 0) ? 24 : 12, NO_CHECK);
      for (int r = 4; r >= 0; r--) begin
        total += ROW_VALUE[r];
        add_step(5, ACT_FIRE, 2, total);
      end
    end
  endtask

  task automatic apply_step(input int idx);
    int act;
    int expected;
    bit ok;
    act      = step_act[idx];
    expected = step_exp[idx];
    @(posedge clk);
    case (act)
      ACT_FIRE:    i_fire    <= 1'b1;
      ACT_RIGHT:   i_right   <= 1'b1;
      ACT_LEFT:    i_left    <= 1'b1;
      default:     i_restart <= 1'b1;
    endcase
    repeat (step_hold[idx]) @(posedge clk);
    i_fire    <= 1'b0;
    i_right   <= 1'b0;
    i_left    <= 1'b0;
    i_restart <= 1'b0;
    if (act == ACT_FIRE) begin
      wait_strobe(1'b0, 2000, ok);  // Bullet flight
      if (!ok) $display("step %0d: the bullet hit no alien", idx);
      if (!ok) note_timeout("no hit strobe after a fire");
    end else begin
      @(negedge clk);
    end
    if (expected != NO_CHECK) compare_value("o_score", int'(o_score), expected);
  endtask

  initial begin
    int err_mark;
    bit ok;
    i_right   <= 1'b0;
    i_left    <= 1'b0;
    i_fire    <= 1'b0;
    i_restart <= 1'b0;
    rst_n     <= 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    err_mark = errors;
    check_sync_timing();
    report_test(1, err_mark);
    err_mark = errors;
    check_blanking();
    report_test(2, err_mark);

    for (int s = 0; s < step_act.size(); s++) begin
      if (s == 0 || step_test[s] != step_test[s-1]) begin
        err_mark = errors;
        if (step_test[s] == 5) compare_value("o_won pulses before the sweep", won_count, 0);
      end
      apply_step(s);
      if (s == step_act.size() - 1 || step_test[s+1] != step_test[s]) begin
        if (step_test[s] != 5) report_test(step_test[s], err_mark);
      end
    end

    // Last alien gone, strobe then cleared score
    wait_strobe(1'b1, 20, ok);
    if (!ok) begin
      note_timeout("o_won did not pulse after the last alien was hit");
    end else begin
      compare_value("o_score while o_won is high", int'(o_score), 990);
      @(negedge clk);
      compare_value("o_score after o_won", int'(o_score), 0);
    end
    compare_value("o_won pulse count", won_count, 1);
    report_test(5, err_mark);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* vga_timing.sv */
module vga_timing (
  input  logic              clk,
  input  logic              rst_n,
  output space_pkg::coord_t o_hpos,
  output space_pkg::coord_t o_vpos,
  output logic              o_active,
  output logic              o_hsync,
  output logic              o_vsync
);
  import space_pkg::*;

  logic h_last;  // Last cycle of a line
  logic v_last;  // Last line of a frame

  assign h_last = (o_hpos == H_TOTAL - 10'd1);
  assign v_last = (o_vpos == V_TOTAL - 10'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else begin
      o_hpos <= h_last ? '0 : o_hpos + 10'd1;
      if (h_last) begin
        o_vpos <= v_last ? '0 : o_vpos + 10'd1;  // Advance once per line
      end
    end
  end

  // Visible region and active-low sync windows
  assign o_active = (o_hpos < H_ACTIVE) && (o_vpos < V_ACTIVE);
  assign o_hsync  = !((o_hpos >= H_SYNC_START) && (o_hpos < H_SYNC_END));  // 96 cycles low
  assign o_vsync  = !((o_vpos >= V_SYNC_START) && (o_vpos < V_SYNC_END));  // Two lines low

endmodule
